// File: rtl/bus_pkg.sv
package bus_pkg;

    ////////////////////////////////////////////////////////////
    // Widths

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    ////////////////////////////////////////////////////////////
    // Step indices of the one-hot timing register

    // Last step of a 4-state opcode read
    localparam int STEP_LAST_RD4   = 11;
    // Last step of 3-state reads, writes and idle cycles
    localparam int STEP_LAST_SHORT = 8;
    localparam int STEP_ALE_OFF    = 1;
    localparam int STEP_STROBE_ON  = 2;
    // Input latch point, also where RD3/WR3 strobes end
    localparam int STEP_LATCH      = 6;
    // /RD release of an opcode read
    localparam int STEP_RD4_END    = 8;

    ////////////////////////////////////////////////////////////
    // Bus cycle and micro-operation encodings

    typedef enum logic [1:0] {
        ACC_IDLE = 2'b00,
        ACC_RD4  = 2'b01,
        ACC_RD3  = 2'b10,
        ACC_WR3  = 2'b11
    } bus_acc_e;

    // Register loaded from wrdata on the tick
    typedef enum logic [2:0] {
        DST_NONE = 3'd0,
        DST_MD   = 3'd1,
        DST_MA   = 3'd2,
        DST_PC   = 3'd3,
        DST_SP   = 3'd4
    } uop_dst_e;

    // Stack action
    typedef enum logic [1:0] {
        SRC_NONE    = 2'd0,
        SRC_SP_POP  = 2'd1,
        SRC_SP_PUSH = 2'd2
    } uop_src_e;

    typedef enum logic [1:0] {
        ASEL_PC = 2'd0,
        ASEL_SP = 2'd1,
        ASEL_MA = 2'd2
    } addr_src_e;

    // One micro-operation, describes the next bus cycle
    typedef struct packed {
        bus_acc_e            next_acc;
        uop_dst_e            dst;
        uop_src_e            src;
        logic [ADDR_W-1:0]   wrdata;
    } uop_t;

    // Timing strobes, all qualified by the clock enable
    typedef struct packed {
        logic                   cycle_tick;
        logic                   opcode_tick;
        logic                   step1;
        logic                   step2;
        logic                   latch_tick;
        logic                   enabled;
        bus_acc_e               acc;
        // Raw one-hot step, not enabled
        logic [STEP_LAST_RD4:0] onehot;
    } step_t;

endpackage

// File: rtl/bus_timing_gen.sv
`timescale 1ns/1ps

module bus_timing_gen (
    input  logic              emuclk,
    input  logic              mrst_n,
    input  logic              i_pcen,
    input  bus_pkg::bus_acc_e i_next_acc,
    output bus_pkg::step_t    o_step
);

    // Step 0 of a fresh cycle
    localparam logic [bus_pkg::STEP_LAST_RD4:0] STEP_FIRST =
        {{bus_pkg::STEP_LAST_RD4{1'b0}}, 1'b1};

    logic [bus_pkg::STEP_LAST_RD4:0] step_sr;
    bus_pkg::bus_acc_e               cur_acc;
    logic                            last_step;
    logic                            acc_is_rd4;
    logic                            acc_is_rd;

    assign acc_is_rd4 = (cur_acc == bus_pkg::ACC_RD4);
    assign acc_is_rd  = acc_is_rd4 | (cur_acc == bus_pkg::ACC_RD3);

    // 12 steps for opcode reads, 9 for everything else
    assign last_step = acc_is_rd4 ? step_sr[bus_pkg::STEP_LAST_RD4]
                                  : step_sr[bus_pkg::STEP_LAST_SHORT];

    ////////////////////////////////////////////////////////////
    // One-hot step shifter

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            // Come out of reset at the start of an opcode read
            step_sr <= STEP_FIRST;
            cur_acc <= bus_pkg::ACC_RD4;
        end else if (i_pcen) begin
            if (last_step) begin
                // Wrap and pick up the next cycle type
                step_sr <= STEP_FIRST;
                cur_acc <= i_next_acc;
            end else begin
                step_sr <= {step_sr[bus_pkg::STEP_LAST_RD4-1:0], 1'b0};
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobe decode

    assign o_step.enabled     = i_pcen;
    assign o_step.acc         = cur_acc;
    assign o_step.onehot      = step_sr;

    // End of cycle, only on an enabled edge
    assign o_step.cycle_tick  = i_pcen & last_step;
    assign o_step.opcode_tick = i_pcen & last_step & acc_is_rd4;

    // ALE release, then strobes on
    assign o_step.step1       = i_pcen & step_sr[bus_pkg::STEP_ALE_OFF];
    assign o_step.step2       = i_pcen & step_sr[bus_pkg::STEP_STROBE_ON];

    // Port sampling point of both read types
    assign o_step.latch_tick  = i_pcen & step_sr[bus_pkg::STEP_LATCH] & acc_is_rd;

endmodule

// File: rtl/addr_reg_unit.sv
`timescale 1ns/1ps

module addr_reg_unit #(
    parameter logic [bus_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                         emuclk,
    input  logic                         mrst_n,
    input  bus_pkg::step_t               i_step,
    input  bus_pkg::uop_t                i_uop,
    output logic [bus_pkg::ADDR_W-1:0]   o_addr,
    output logic                         o_push_load
);

    localparam logic [bus_pkg::ADDR_W-1:0] ONE = {{(bus_pkg::ADDR_W-1){1'b0}}, 1'b1};

    logic [bus_pkg::ADDR_W-1:0] pc;
    logic [bus_pkg::ADDR_W-1:0] sp;
    logic [bus_pkg::ADDR_W-1:0] ma;
    bus_pkg::addr_src_e         asel;
    bus_pkg::addr_src_e         asel_next;
    // 1 = SP counts up (pop), 0 = SP counts down (push)
    logic                       sp_inc_ndec;
    logic                       sp_inc_ndec_next;
    logic                       pc_wr;
    logic                       sp_wr;
    logic                       ma_wr;
    logic                       sp_push;
    logic                       sp_pop;
    logic                       end_of_instr;
    logic                       next_is_rd;
    logic                       next_is_rw3;
    logic                       pc_step;
    logic                       sp_step;
    logic                       ma_step;

    ////////////////////////////////////////////////////////////
    // Micro-operation decode

    assign pc_wr   = (i_uop.dst == bus_pkg::DST_PC);
    assign sp_wr   = (i_uop.dst == bus_pkg::DST_SP);
    assign ma_wr   = (i_uop.dst == bus_pkg::DST_MA);
    assign sp_push = (i_uop.src == bus_pkg::SRC_SP_PUSH);
    assign sp_pop  = (i_uop.src == bus_pkg::SRC_SP_POP);

    // Next opcode fetch closes the instruction
    assign end_of_instr = (i_uop.next_acc == bus_pkg::ACC_RD4);
    assign next_is_rd   = end_of_instr | (i_uop.next_acc == bus_pkg::ACC_RD3);
    assign next_is_rw3  = (i_uop.next_acc == bus_pkg::ACC_RD3) |
                          (i_uop.next_acc == bus_pkg::ACC_WR3);

    // Push setup, shared with the data unit
    assign o_push_load = i_step.cycle_tick & sp_push & ma_wr;

    // Address source for the coming cycle
    always_comb begin
        asel_next = asel;
        if (end_of_instr) begin
            asel_next = bus_pkg::ASEL_PC;
        end else if (pc_wr) begin
            asel_next = bus_pkg::ASEL_PC;
        end else if ((sp_push | sp_pop) & ma_wr) begin
            asel_next = bus_pkg::ASEL_SP;
        end else if (ma_wr) begin
            asel_next = bus_pkg::ASEL_MA;
        end
    end

    always_comb begin
        sp_inc_ndec_next = sp_inc_ndec;
        if (end_of_instr) begin
            sp_inc_ndec_next = 1'b1;
        end else if (sp_push & ma_wr) begin
            sp_inc_ndec_next = 1'b0;
        end
    end

    // PC steps only for fetches that use it
    assign pc_step = next_is_rd & (asel_next == bus_pkg::ASEL_PC) & ~ma_wr;
    // Push predecrements, pop postincrements
    assign sp_step = next_is_rw3 & (asel_next == bus_pkg::ASEL_SP) &
                     (~sp_inc_ndec_next | (asel == bus_pkg::ASEL_SP));
    assign ma_step = next_is_rw3 & (asel_next == bus_pkg::ASEL_MA);

    ////////////////////////////////////////////////////////////
    // PC / SP / MA

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            pc          <= RESET_PC;
            sp          <= '0;
            ma          <= '0;
            asel        <= bus_pkg::ASEL_PC;
            sp_inc_ndec <= 1'b1;
        end else if (i_step.cycle_tick) begin
            asel        <= asel_next;
            sp_inc_ndec <= sp_inc_ndec_next;

            // 16-bit arithmetic wraps FFFF/0000 both ways
            if (pc_wr) begin
                pc <= i_uop.wrdata;
            end else if (pc_step) begin
                pc <= pc + ONE;
            end

            if (sp_wr) begin
                sp <= i_uop.wrdata;
            end else if (sp_step) begin
                sp <= sp_inc_ndec_next ? (sp + ONE) : (sp - ONE);
            end

            // Track the fetched address after an opcode read
            if (ma_wr) begin
                ma <= i_uop.wrdata;
            end else if (i_step.opcode_tick) begin
                ma <= pc;
            end else if (ma_step) begin
                ma <= ma + ONE;
            end
        end
    end

    // Address out
    always_comb begin
        case (asel)
            bus_pkg::ASEL_SP: o_addr = sp;
            bus_pkg::ASEL_MA: o_addr = ma;
            default:          o_addr = pc;
        endcase
    end

endmodule

// File: rtl/mem_data_unit.sv
`timescale 1ns/1ps

module mem_data_unit (
    input  logic                           emuclk,
    input  logic                           mrst_n,
    input  bus_pkg::step_t                 i_step,
    input  bus_pkg::uop_t                  i_uop,
    input  logic                           i_push_load,
    input  logic [bus_pkg::DATA_W-1:0]     i_pd_i,
    output logic [bus_pkg::DATA_W-1:0]     o_data_byte,
    output logic [2*bus_pkg::DATA_W-1:0]   o_md,
    output logic [bus_pkg::DATA_W-1:0]     o_opcode
);

    localparam int DW = bus_pkg::DATA_W;

    logic [2*DW-1:0] md;
    logic [DW-1:0]   opcode;
    // Byte selects, 0 = low byte
    logic            in_sel;
    logic            out_sel;
    logic            md_wr;
    logic            end_of_instr;
    logic            acc_rd3;
    logic            acc_rd4;
    logic            acc_wr3;

    assign md_wr        = (i_uop.dst == bus_pkg::DST_MD);
    assign end_of_instr = (i_uop.next_acc == bus_pkg::ACC_RD4);

    // Type of the cycle that is running now
    assign acc_rd3 = (i_step.acc == bus_pkg::ACC_RD3);
    assign acc_rd4 = (i_step.acc == bus_pkg::ACC_RD4);
    assign acc_wr3 = (i_step.acc == bus_pkg::ACC_WR3);

    ////////////////////////////////////////////////////////////
    // Byte order bookkeeping

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            in_sel  <= 1'b0;
            out_sel <= 1'b0;
        end else if (i_step.cycle_tick) begin
            if (end_of_instr) begin
                in_sel  <= 1'b0;
                out_sel <= 1'b0;
            end else begin
                // Push writes high byte first
                if (i_push_load) begin
                    out_sel <= 1'b1;
                end else if (acc_wr3) begin
                    out_sel <= ~out_sel;
                end

                // Reads always fill low then high
                if (acc_rd3) begin
                    in_sel <= ~in_sel;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // MD and opcode

    always_ff @(posedge emuclk) begin
        // Word load wins over a byte from the port
        if (i_step.cycle_tick && md_wr) begin
            md <= i_uop.wrdata;
        end else if (i_step.latch_tick && acc_rd3) begin
            if (in_sel) begin
                md[2*DW-1:DW] <= i_pd_i;
            end else begin
                md[DW-1:0] <= i_pd_i;
            end
        end

        if (i_step.latch_tick && acc_rd4) begin
            opcode <= i_pd_i;
        end
    end

    // Outgoing byte
    assign o_data_byte = out_sel ? md[2*DW-1:DW] : md[DW-1:0];
    assign o_md        = md;
    assign o_opcode    = opcode;

endmodule

// File: rtl/bus_pin_ctrl.sv
`timescale 1ns/1ps

module bus_pin_ctrl (
    input  logic                         emuclk,
    input  logic                         mrst_n,
    input  bus_pkg::step_t               i_step,
    input  bus_pkg::bus_acc_e            i_next_acc,
    input  logic [bus_pkg::ADDR_W-1:0]   i_addr,
    input  logic [bus_pkg::DATA_W-1:0]   i_data_byte,
    output logic                         o_ale,
    output logic                         o_rd_n,
    output logic                         o_wr_n,
    output logic [bus_pkg::DATA_W-1:0]   o_pa_o,
    output logic [bus_pkg::DATA_W-1:0]   o_pd_o,
    output logic [bus_pkg::DATA_W-1:0]   o_pd_dir
);

    localparam int DW = bus_pkg::DATA_W;

    // 0 = address on the port, 1 = data
    logic          data_phase;
    logic          ale;
    logic          rd;
    logic          wr;
    logic [DW-1:0] pd_dir;
    logic          strobe_off;
    logic          acc_read;
    logic          acc_active;
    logic          next_active;

    assign acc_read    = (i_step.acc == bus_pkg::ACC_RD4) | (i_step.acc == bus_pkg::ACC_RD3);
    assign acc_active  = (i_step.acc != bus_pkg::ACC_IDLE);
    assign next_active = (i_next_acc != bus_pkg::ACC_IDLE);

    // Strobe release point per cycle type
    always_comb begin
        case (i_step.acc)
            bus_pkg::ACC_RD4: begin
                strobe_off = i_step.enabled & i_step.onehot[bus_pkg::STEP_RD4_END];
            end
            bus_pkg::ACC_RD3,
            bus_pkg::ACC_WR3: begin
                strobe_off = i_step.enabled & i_step.onehot[bus_pkg::STEP_LATCH];
            end
            default: begin
                strobe_off = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pin state

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            data_phase <= 1'b0;
            ale        <= 1'b0;
            rd         <= 1'b0;
            wr         <= 1'b0;
            pd_dir     <= '0;
        end else if (i_step.cycle_tick) begin
            // New cycle starts with the address phase
            data_phase <= 1'b0;
            ale        <= next_active;
            pd_dir     <= next_active ? '1 : '0;
        end else begin
            if (i_step.step1) begin
                ale <= 1'b0;
            end

            if (i_step.step2 && acc_active) begin
                data_phase <= 1'b1;
                rd         <= acc_read;
                wr         <= ~acc_read;
                // Let the memory drive during reads
                if (acc_read) begin
                    pd_dir <= '0;
                end
            end else if (strobe_off) begin
                rd <= 1'b0;
                wr <= 1'b0;
            end
        end
    end

    // Address high byte always, low byte muxed with data
    assign o_pa_o   = i_addr[bus_pkg::ADDR_W-1:DW];
    assign o_pd_o   = data_phase ? i_data_byte : i_addr[DW-1:0];
    assign o_pd_dir = pd_dir;
    assign o_ale    = ale;
    assign o_rd_n   = ~rd;
    assign o_wr_n   = ~wr;

endmodule

// File: rtl/bus_cycle_unit.sv
`timescale 1ns/1ps

module bus_cycle_unit #(
    parameter logic [bus_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                           emuclk,
    input  logic                           mrst_n,
    input  logic                           i_mcuclk_pcen,
    input  bus_pkg::uop_t                  i_uop,
    input  logic [bus_pkg::DATA_W-1:0]     i_pd_i,
    output logic                           o_cycle_tick,
    output logic                           o_ale,
    output logic                           o_rd_n,
    output logic                           o_wr_n,
    output logic [bus_pkg::DATA_W-1:0]     o_pa_o,
    output logic [bus_pkg::DATA_W-1:0]     o_pd_o,
    output logic [bus_pkg::DATA_W-1:0]     o_pd_dir,
    output logic [bus_pkg::DATA_W-1:0]     o_opcode,
    output logic [2*bus_pkg::DATA_W-1:0]   o_md
);

    bus_pkg::step_t               step;
    logic [bus_pkg::ADDR_W-1:0]   bus_addr;
    logic [bus_pkg::DATA_W-1:0]   data_byte;
    logic                         push_load;

    // Micro-operation is consumed here
    assign o_cycle_tick = step.cycle_tick;

    ////////////////////////////////////////////////////////////
    // Step sequencing

    bus_timing_gen u_timing (
        .emuclk     (emuclk),
        .mrst_n     (mrst_n),
        .i_pcen     (i_mcuclk_pcen),
        .i_next_acc (i_uop.next_acc),
        .o_step     (step)
    );

    ////////////////////////////////////////////////////////////
    // Address and data paths

    addr_reg_unit #(
        .RESET_PC (RESET_PC)
    ) u_addr (
        .emuclk      (emuclk),
        .mrst_n      (mrst_n),
        .i_step      (step),
        .i_uop       (i_uop),
        .o_addr      (bus_addr),
        .o_push_load (push_load)
    );

    mem_data_unit u_data (
        .emuclk      (emuclk),
        .mrst_n      (mrst_n),
        .i_step      (step),
        .i_uop       (i_uop),
        .i_push_load (push_load),
        .i_pd_i      (i_pd_i),
        .o_data_byte (data_byte),
        .o_md        (o_md),
        .o_opcode    (o_opcode)
    );

    // Pins
    bus_pin_ctrl u_pins (
        .emuclk      (emuclk),
        .mrst_n      (mrst_n),
        .i_step      (step),
        .i_next_acc  (i_uop.next_acc),
        .i_addr      (bus_addr),
        .i_data_byte (data_byte),
        .o_ale       (o_ale),
        .o_rd_n      (o_rd_n),
        .o_wr_n      (o_wr_n),
        .o_pa_o      (o_pa_o),
        .o_pd_o      (o_pd_o),
        .o_pd_dir    (o_pd_dir)
    );

endmodule

// File: verif/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Pseudo random source for the clock enable
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks, X in the expected value must match X

task automatic check_addr(input string name, input logic [bus_pkg::ADDR_W-1:0] got,
                          input logic [bus_pkg::ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_byte(input string name, input logic [bus_pkg::DATA_W-1:0] got,
                          input logic [bus_pkg::DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

// MD word
task automatic check_md(input string name, input logic [2*bus_pkg::DATA_W-1:0] got,
                        input logic [2*bus_pkg::DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_acc(input string name, input bus_pkg::bus_acc_e got,
                         input bus_pkg::bus_acc_e exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s got %s expected %s", $time, name, got.name(),
                 exp.name());
    end
endtask

`endif

// File: verif/tb_bus_cycle_unit.sv
`timescale 1ns/1ps

module tb_bus_cycle_unit;

    logic                        emuclk;
    logic                        mrst_n;
    logic                        i_mcuclk_pcen;
    bus_pkg::uop_t               i_uop;
    logic [7:0]                  i_pd_i;
    logic                        o_cycle_tick;
    logic                        o_ale;
    logic                        o_rd_n;
    logic                        o_wr_n;
    logic [7:0]                  o_pa_o;
    logic [7:0]                  o_pd_o;
    logic [7:0]                  o_pd_dir;
    logic [7:0]                  o_opcode;
    logic [15:0]                 o_md;

    // Test line of 21 hex digits
    // Fields acc dst src wrdata rd_byte addr data opcode md
    logic [83:0] tests [0:63];
    int          n_tests;
    int          errors;
    int          checks;
    logic [31:0] rng;

    `include "tb_checks.svh"

    bus_cycle_unit #(
        .RESET_PC (16'h4000)
    ) u_bus_cycle_unit (
        .emuclk        (emuclk),
        .mrst_n        (mrst_n),
        .i_mcuclk_pcen (i_mcuclk_pcen),
        .i_uop         (i_uop),
        .i_pd_i        (i_pd_i),
        .o_cycle_tick  (o_cycle_tick),
        .o_ale         (o_ale),
        .o_rd_n        (o_rd_n),
        .o_wr_n        (o_wr_n),
        .o_pa_o        (o_pa_o),
        .o_pd_o        (o_pd_o),
        .o_pd_dir      (o_pd_dir),
        .o_opcode      (o_opcode),
        .o_md          (o_md)
    );

    initial begin
        emuclk = 1'b0;
        forever #20 emuclk = ~emuclk;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic apply_uop(input int idx);
        i_uop.next_acc = bus_pkg::bus_acc_e'(tests[idx][81:80]);
        i_uop.dst      = bus_pkg::uop_dst_e'(tests[idx][78:76]);
        i_uop.src      = bus_pkg::uop_src_e'(tests[idx][73:72]);
        i_uop.wrdata   = tests[idx][71:56];
    endtask

    // Cycle type from strobe lengths in enabled steps
    function automatic bus_pkg::bus_acc_e infer_acc(input int rd_cnt, input int wr_cnt,
                                                    output bit valid);
        valid = 1'b1;
        if (rd_cnt == 6 && wr_cnt == 0) return bus_pkg::ACC_RD4;
        if (rd_cnt == 4 && wr_cnt == 0) return bus_pkg::ACC_RD3;
        if (rd_cnt == 0 && wr_cnt == 4) return bus_pkg::ACC_WR3;
        valid = (rd_cnt == 0 && wr_cnt == 0);
        return bus_pkg::ACC_IDLE;
    endfunction

    // One bus cycle entered 2 ns after an edge
    task automatic run_cycle(input int idx);
        logic [83:0]       t;
        int                rd_cnt;
        int                wr_cnt;
        int                en_cnt;
        int                err0;
        bit                strobe_seen;
        bit                ale_seen;
        bit                tick;
        bit                valid;
        logic [15:0]       addr_cap;
        logic [7:0]        wbyte;
        logic [7:0]        wdir;
        logic [7:0]        opc_cap;
        logic [15:0]       md_cap;
        bus_pkg::bus_acc_e exp_acc;
        bus_pkg::bus_acc_e got_acc;
        t           = tests[idx];
        rd_cnt      = 0;
        wr_cnt      = 0;
        en_cnt      = 0;
        err0        = errors;
        strobe_seen = 1'b0;
        ale_seen    = 1'b0;
        tick        = 1'b0;
        addr_cap    = 'x;
        wbyte       = 'x;
        wdir        = 'x;
        opc_cap     = 'x;
        md_cap      = 'x;
        exp_acc     = (idx == 0) ? bus_pkg::ACC_RD4
                                 : bus_pkg::bus_acc_e'(tests[idx-1][81:80]);
        while (!tick) begin
            rng           = xorshift32(rng);
            i_mcuclk_pcen = (rng[1:0] != 2'b00);
            // Memory model answers only while /RD is low
            i_pd_i        = !o_rd_n ? t[55:48] : 8'h00;
            // Levels held until the next rising edge
            @(negedge emuclk);
            if (i_mcuclk_pcen) en_cnt++;
            if (o_ale) ale_seen = 1'b1;
            if (!o_rd_n || !o_wr_n) begin
                strobe_seen = 1'b1;
            end else if (!strobe_seen) begin
                addr_cap = {o_pa_o, o_pd_o};
            end
            if (!o_rd_n && i_mcuclk_pcen) rd_cnt++;
            if (!o_wr_n && i_mcuclk_pcen) wr_cnt++;
            if (!o_wr_n) begin
                wbyte = o_pd_o;
                wdir  = o_pd_dir;
            end
            opc_cap = o_opcode;
            md_cap  = o_md;
            tick    = o_cycle_tick;
            @(posedge emuclk);
            #2;
        end

        // Results as seen before the closing tick
        got_acc = infer_acc(rd_cnt, wr_cnt, valid);
        if (!valid) begin
            errors++;
            $display("Strobe pattern rd %0d wr %0d fits no bus cycle", rd_cnt, wr_cnt);
        end
        check_acc("bus cycle", got_acc, exp_acc);
        if (en_cnt != ((exp_acc == bus_pkg::ACC_RD4) ? 12 : 9)) begin
            errors++;
            $display("Cycle %0d lasted %0d enabled steps", idx, en_cnt);
        end
        if (exp_acc != bus_pkg::ACC_IDLE) begin
            check_addr("bus address", addr_cap, t[47:32]);
        end
        // No ALE for the first cycle out of reset or an idle cycle
        check_bit("o_ale pulse", ale_seen, (idx > 0) && (exp_acc != bus_pkg::ACC_IDLE));
        if (exp_acc == bus_pkg::ACC_WR3) begin
            check_byte("o_pd_o", wbyte, t[31:24]);
            check_byte("o_pd_dir", wdir, 8'hff);
        end
        check_byte("o_opcode", opc_cap, t[23:16]);
        check_md("o_md", md_cap, t[15:0]);
        $display("test %0d %s at %h: %s", idx, exp_acc.name(), addr_cap,
                 (errors == err0) ? "ok" : "mismatch");

        if (idx + 1 < n_tests) apply_uop(idx + 1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        errors        = 0;
        checks        = 0;
        rng           = 32'h4311_392b;
        mrst_n        = 1'b0;
        // Enable held high through reset
        i_mcuclk_pcen = 1'b1;
        i_uop         = '0;
        i_pd_i        = '0;
        foreach (tests[i]) begin
            tests[i] = '1;
        end
        $readmemh("verif/bus_cycle_tests.dat", tests);
        n_tests = 0;
        // Lines not in the file keep acc nibble F
        while (n_tests < 64 && tests[n_tests][83:80] != 4'hf) n_tests++;
        if (n_tests == 0) begin
            $display("No test lines found in verif/bus_cycle_tests.dat");
            $display("Simulation FAILED");
            $finish;
        end else begin
            apply_uop(0);
            repeat (5) @(posedge emuclk);
            #2;
            mrst_n = 1'b1;
            // Idle pins straight out of reset
            check_bit("o_ale", o_ale, 1'b0);
            check_bit("o_rd_n", o_rd_n, 1'b1);
            check_bit("o_wr_n", o_wr_n, 1'b1);
            check_bit("o_cycle_tick", o_cycle_tick, 1'b0);
            check_byte("o_pd_dir", o_pd_dir, 8'h00);
            for (int i = 0; i < n_tests; i++) begin
                run_cycle(i);
            end
            $display("tests %0d checks %0d errors %0d", n_tests, checks, errors);
            if (errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

    // Twice twelve steps per line at 3 in 4 enabled edges
    initial begin
        longint limit;
        #1;
        limit = longint'(n_tests) * 12 * 4 * 2 * 40 / 3 + 4000;
        #(limit);
        $display("Watchdog expired after %0d ns, bus cycles did not finish", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: project.f
+incdir+verif
rtl/bus_pkg.sv
rtl/bus_timing_gen.sv
rtl/addr_reg_unit.sv
rtl/mem_data_unit.sv
rtl/bus_pin_ctrl.sv
rtl/bus_cycle_unit.sv
verif/tb_bus_cycle_unit.sv

// File: run.sh
#!/bin/sh
# Compile and run the bus cycle testbench with Verilator
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing \
    -f project.f \
    --top-module tb_bus_cycle_unit \
    -Mdir build/obj

./build/obj/Vtb_bus_cycle_unit | tee build/sim.log

if grep -qx "Simulation PASSED" build/sim.log; then
    exit 0
else
    echo "run.sh: pass message not found in build/sim.log"
    exit 1
fi

// File: verif/bus_cycle_tests.dat
// One bus cycle per line, uop is consumed at the end of that cycle
// acc_dst_src_wrdata_rdbyte_addr_data_opcode_md (acc 0 idle 1 rd4 2 rd3 3 wr3)
1_0_0_0000_3E_4000_xx_3E_xxxx
1_3_0_FFFE_00_4001_xx_00_xxxx
1_0_0_0000_C3_FFFE_xx_C3_xxxx
1_0_0_0000_21_FFFF_xx_21_xxxx
2_2_0_8100_2A_0000_xx_2A_xxxx
2_0_0_0000_34_8100_xx_2A_xx34
1_0_0_0000_12_8101_xx_2A_1234
1_4_0_9000_C5_0001_xx_C5_1234
3_2_2_0000_9A_0002_xx_9A_1234
3_0_0_0000_00_8FFF_12_9A_1234
1_0_0_0000_00_8FFE_34_9A_1234
2_2_1_0000_D1_0003_xx_D1_1234
2_0_0_0000_78_8FFE_xx_D1_1278
1_0_0_0000_56_8FFF_xx_D1_5678
3_1_0_BEEF_E5_0004_xx_E5_5678
3_0_0_0000_00_0004_EF_E5_BEEF
0_0_0_0000_00_0004_BE_E5_BEEF
1_0_0_0000_00_xxxx_xx_E5_BEEF
1_0_0_0000_4F_0005_xx_4F_BEEF
1_0_0_0000_76_0006_xx_76_BEEF
